//--- run.sh
#!/usr/bin/env bash
# builds the dma channel testbench with Verilator and runs it

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f tb.f --top-module dmaTb -o dmaSim &&
./obj_dir/dmaSim | tee /dev/stderr | grep -qx "TEST OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- source/dmaAddressPath.sv
`timescale 1ns/10ps
`default_nettype none

module dmaAddressPath (
  input  logic clk,
  input  logic rst_b,
  input  dmaPkg::dmaConfig_t cfg,
  input  logic loadAll,
  input  logic stepSrc,
  input  logic stepDst,
  input  logic storeData,
  input  logic issueRead,
  input  logic issueWrite,
  input  logic reloadDst,
  input  dmaPkg::memRsp_t memRsp,
  output dmaPkg::memReq_t memReq,
  output logic newConfig
);
  import dmaPkg::*;

  logic [31:0] srcAddr;
  logic [31:0] dstAddr;
  logic [31:0] dataHold;
  logic [31:0] addrStep;
  logic [31:0] srcNext;
  logic [31:0] dstNext;
  logic dstReload;
  dmaConfig_t cfgPrev;

  function automatic logic [31:0] stepAddr(input logic [31:0] addr, input addrCtl_e ctl,
                                           input logic [31:0] inc);
    logic [31:0] result;
    case (ctl)
      addrDec: result = addr - inc;
      addrFixed: result = addr;
      default: result = addr + inc; // addrInc and addrIncReload
    endcase
    return result;
  endfunction

  assign addrStep = cfg.wordSize ? 32'd4 : 32'd2;
  assign srcNext = stepAddr(srcAddr, cfg.srcCtl, addrStep);
  assign dstNext = stepAddr(dstAddr, cfg.dstCtl, addrStep);
  assign dstReload = reloadDst && (cfg.dstCtl == addrIncReload);

  always_ff @(posedge clk) begin
    if (loadAll)
      srcAddr <= cfg.srcAddr;
    else if (stepSrc)
      srcAddr <= srcNext;
  end

  always_ff @(posedge clk) begin
    if (loadAll || dstReload)
      dstAddr <= cfg.dstAddr;
    else if (stepDst)
      dstAddr <= dstNext;
  end

  always_ff @(posedge clk) begin
    if (storeData)
      dataHold <= memRsp.rdata;
  end

  // copy of cfg one cycle behind, any difference is a fresh setup
  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b)
      cfgPrev <= '0;
    else
      cfgPrev <= cfg;
  end

  assign newConfig = (cfg != cfgPrev);

  always_comb begin
    memReq.valid = issueRead | issueWrite;
    memReq.write = issueWrite;
    memReq.size = cfg.wordSize ? 2'd2 : 2'd1;
    memReq.addr = issueWrite ? dstAddr : srcAddr;
    memReq.wdata = issueWrite ? dataHold : '0;
  end

endmodule : dmaAddressPath

`default_nettype wire

//--- source/dmaChannel.sv
`timescale 1ns/10ps
`default_nettype none

module dmaChannel #(
  parameter int MEM_CREDITS = 2
) (
  input  logic clk,
  input  logic rst_b,
  input  dmaPkg::dmaConfig_t cfg,
  input  logic [15:0] hcount,
  input  logic [15:0] vcount,
  input  dmaPkg::memRsp_t memRsp,
  input  logic creditReturn,
  output dmaPkg::memReq_t memReq,
  output logic active,
  output logic irq,
  output logic disableDma
);

  logic start;
  logic newConfig;
  logic lastUnit;
  logic creditAvail;
  logic loadAll;
  logic stepSrc;
  logic stepDst;
  logic storeData;
  logic countUnit;
  logic issueRead;
  logic issueWrite;
  logic restart;
  logic counterClear;

  assign counterClear = loadAll | restart; // fresh count on load and on every repeat

  dmaStartSync i_startSync (
    .clk, .rst_b, .startMode(cfg.startMode), .hcount, .vcount, .start
  );

  dmaSequencer i_sequencer (
    .clk, .rst_b, .cfg, .start, .newConfig, .lastUnit, .creditAvail,
    .rspValid(memRsp.valid), .loadAll, .stepSrc, .stepDst, .storeData, .countUnit,
    .issueRead, .issueWrite, .restart, .active, .irq, .disableDma
  );

  dmaUnitCounter i_unitCounter (
    .clk, .rst_b, .clear(counterClear), .countUnit, .unitCount(cfg.unitCount), .lastUnit
  );

  dmaCreditTracker #(
    .MEM_CREDITS(MEM_CREDITS)
  ) i_creditTracker (
    .clk, .rst_b, .spend(memReq.valid), .creditReturn, .creditAvail
  );

  dmaAddressPath i_addressPath (
    .clk, .rst_b, .cfg, .loadAll, .stepSrc, .stepDst, .storeData, .issueRead,
    .issueWrite, .reloadDst(restart), .memRsp, .memReq, .newConfig
  );

endmodule : dmaChannel

`default_nettype wire

//--- source/dmaCreditTracker.sv
`timescale 1ns/10ps
`default_nettype none

module dmaCreditTracker #(
  parameter int MEM_CREDITS = 2
) (
  input  logic clk,
  input  logic rst_b,
  input  logic spend,
  input  logic creditReturn,
  output logic creditAvail
);

  localparam int CW = $clog2(MEM_CREDITS + 1);

  logic [CW-1:0] freeSlots;

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      freeSlots <= CW'(MEM_CREDITS);
    end else begin
      case ({spend, creditReturn})
        2'b10: freeSlots <= freeSlots - 1'b1;
        2'b01: freeSlots <= freeSlots + 1'b1;
        default: freeSlots <= freeSlots; // both or neither cancel out
      endcase
    end
  end

  assign creditAvail = (freeSlots != '0);

endmodule : dmaCreditTracker

`default_nettype wire

//--- source/dmaPkg.sv
`default_nettype none

package dmaPkg;

  localparam logic [7:0] HBLANK_LINE_END = 8'd240; // hcount where hblank begins
  localparam logic [7:0] VBLANK_LINE = 8'd160; // vcount where vblank begins

  typedef enum logic [1:0] {
    addrInc = 2'd0,
    addrDec = 2'd1,
    addrFixed = 2'd2,
    addrIncReload = 2'd3 // dst only, reloaded on every repeat
  } addrCtl_e;

  typedef enum logic [1:0] {
    startNow = 2'd0,
    startVblank = 2'd1,
    startHblank = 2'd2
  } startMode_e;

  typedef enum logic [2:0] {
    stOff,
    stIdle,
    stRead,
    stReadWait,
    stWrite,
    stWriteWait
  } seqState_e;

  typedef struct packed {
    logic [31:0] srcAddr;
    logic [31:0] dstAddr;
    logic [13:0] unitCount; // 0 means 16384 units
    addrCtl_e srcCtl;
    addrCtl_e dstCtl;
    logic wordSize; // 1 for word, 0 for halfword
    logic repeatEn;
    startMode_e startMode;
    logic irqEn;
    logic enable;
  } dmaConfig_t;

  typedef struct packed {
    logic valid;
    logic write;
    logic [1:0] size; // 1 halfword, 2 word
    logic [31:0] addr;
    logic [31:0] wdata;
  } memReq_t;

  typedef struct packed {
    logic valid;
    logic [31:0] rdata;
  } memRsp_t;

endpackage : dmaPkg

`default_nettype wire

//--- source/dmaSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module dmaSequencer (
  input  logic clk,
  input  logic rst_b,
  input  dmaPkg::dmaConfig_t cfg,
  input  logic start,
  input  logic newConfig,
  input  logic lastUnit,
  input  logic creditAvail,
  input  logic rspValid,
  output logic loadAll,
  output logic stepSrc,
  output logic stepDst,
  output logic storeData,
  output logic countUnit,
  output logic issueRead,
  output logic issueWrite,
  output logic restart,
  output logic active,
  output logic irq,
  output logic disableDma
);
  import dmaPkg::*;

  seqState_e state, nextState;
  logic finalUnit; // the write just issued was the last one

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      state <= stOff;
      finalUnit <= 1'b0;
    end else begin
      state <= nextState;
      if (issueWrite)
        finalUnit <= lastUnit;
    end
  end

  always_comb begin
    nextState = state;
    loadAll = 1'b0;
    stepSrc = 1'b0;
    stepDst = 1'b0;
    storeData = 1'b0;
    countUnit = 1'b0;
    issueRead = 1'b0;
    issueWrite = 1'b0;
    restart = 1'b0;
    irq = 1'b0;
    disableDma = 1'b0;
    case (state)
      stOff: begin
        if (cfg.enable && newConfig) begin
          loadAll = 1'b1;
          nextState = stIdle;
        end
      end
      stIdle: begin
        if (!cfg.enable)
          nextState = stOff;
        else if (newConfig)
          loadAll = 1'b1; // rewritten while armed
        else if (start)
          nextState = stRead;
      end
      stRead: begin
        if (creditAvail) begin
          issueRead = 1'b1;
          nextState = stReadWait;
        end
      end
      stReadWait: begin
        if (rspValid) begin
          storeData = 1'b1;
          stepSrc = 1'b1;
          nextState = stWrite;
        end
      end
      stWrite: begin
        if (creditAvail) begin
          issueWrite = 1'b1;
          stepDst = 1'b1;
          countUnit = 1'b1;
          nextState = stWriteWait;
        end
      end
      stWriteWait: begin
        if (finalUnit) begin
          irq = cfg.irqEn;
          if (cfg.repeatEn) begin
            restart = 1'b1; // rearm and wait for the next trigger
            nextState = stIdle;
          end else begin
            disableDma = 1'b1;
            nextState = stOff;
          end
        end else begin
          nextState = stRead;
        end
      end
      default: nextState = stOff;
    endcase
  end

  assign active = (state == stRead) || (state == stReadWait) ||
                  (state == stWrite) || (state == stWriteWait);

endmodule : dmaSequencer

`default_nettype wire

//--- source/dmaStartSync.sv
`timescale 1ns/10ps
`default_nettype none

module dmaStartSync (
  input  logic clk,
  input  logic rst_b,
  input  dmaPkg::startMode_e startMode,
  input  logic [15:0] hcount,
  input  logic [15:0] vcount,
  output logic start
);
  import dmaPkg::*;

  logic match;
  logic prevMatch;

  always_comb begin
    case (startMode)
      startHblank: match = (hcount[7:0] == HBLANK_LINE_END);
      startVblank: match = (vcount[7:0] == VBLANK_LINE);
      default: match = 1'b0;
    endcase
  end

  // counters can sit on one value for many clocks
  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b)
      prevMatch <= 1'b0;
    else
      prevMatch <= match;
  end

  always_comb begin
    if (startMode == startNow)
      start = 1'b1;
    else
      start = match & ~prevMatch; // first cycle of the blank only
  end

endmodule : dmaStartSync

`default_nettype wire

//--- source/dmaUnitCounter.sv
`timescale 1ns/10ps
`default_nettype none

module dmaUnitCounter (
  input  logic clk,
  input  logic rst_b,
  input  logic clear,
  input  logic countUnit,
  input  logic [13:0] unitCount,
  output logic lastUnit
);

  logic [13:0] doneUnits;
  logic [13:0] nextUnits;

  assign nextUnits = doneUnits + 14'd1; // wraps, so a count of 0 runs 16384 units

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b)
      doneUnits <= '0;
    else if (clear)
      doneUnits <= '0;
    else if (countUnit)
      doneUnits <= nextUnits;
  end

  assign lastUnit = (nextUnits == unitCount);

endmodule : dmaUnitCounter

`default_nettype wire

//--- tb.f
source/dmaPkg.sv
source/dmaStartSync.sv
source/dmaSequencer.sv
source/dmaUnitCounter.sv
source/dmaCreditTracker.sv
source/dmaAddressPath.sv
source/dmaChannel.sv
testbench/dmaChecker.sv
testbench/dmaTb.sv

//--- testbench/dmaChecker.sv
`timescale 1ns/10ps
`default_nettype none

module dmaChecker #(
  parameter int MEM_CREDITS = 2,
  parameter logic [31:0] DATA_PATTERN = 32'h0
) (
  input  logic clk,
  input  logic rst_b,
  input  dmaPkg::dmaConfig_t cfg,
  input  logic [15:0] hcount,
  input  logic [15:0] vcount,
  input  dmaPkg::memReq_t memReq,
  input  logic creditReturn,
  input  logic active,
  input  logic irq,
  input  logic disableDma,
  input  logic rowDone,
  input  logic [3:0] rowExpIrq,
  input  logic rowExpDis,
  output int errCount,
  output int checkCount
);
  import dmaPkg::*;

  dmaConfig_t cfgSeen;
  logic [31:0] expSrc;
  logic [31:0] expDst;
  logic [31:0] expData;
  int unitsDone;
  int outstanding;
  int irqCount;
  int disCount;
  int errors = 0;
  int checks = 0;
  logic endDue; // cycle after the final write
  logic trigSeen;
  logic chanOff;

  assign errCount = errors;
  assign checkCount = checks;

  function automatic logic [31:0] nextAddr(input logic [31:0] addr, input addrCtl_e ctl,
                                           input logic word);
    logic [31:0] step;
    step = word ? 32'd4 : 32'd2;
    case (ctl)
      addrDec: return addr - step;
      addrFixed: return addr;
      default: return addr + step;
    endcase
  endfunction

  task automatic expectEqual(input logic [31:0] got, input logic [31:0] want,
                             input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  always @(posedge clk) begin : watch
    logic lastWrite;
    lastWrite = 1'b0;
    if (!rst_b) begin
      expectEqual(32'(memReq.valid), 32'd0, "memReq.valid in reset");
      expectEqual(32'(active), 32'd0, "active in reset");
      expectEqual(32'(irq), 32'd0, "irq in reset");
      cfgSeen = '0;
      outstanding = 0;
      unitsDone = 0;
      irqCount = 0;
      disCount = 0;
      endDue = 1'b0;
      trigSeen = 1'b0;
      chanOff = 1'b1;
    end else begin
      expectEqual(32'(irq), endDue ? 32'(cfg.irqEn) : 32'd0, "irq");
      expectEqual(32'(disableDma), 32'(endDue && !cfg.repeatEn), "disableDma");
      if (chanOff) begin
        expectEqual(32'(memReq.valid), 32'd0, "memReq.valid while off");
        expectEqual(32'(active), 32'd0, "active while off");
      end
      outstanding = outstanding + int'(memReq.valid) - int'(creditReturn);
      checks++;
      if (outstanding > MEM_CREDITS || outstanding < 0) begin
        errors++;
        $display("ERR %0t: %0d requests outstanding with %0d credits", $time, outstanding,
                 MEM_CREDITS);
      end
      if (memReq.valid) begin
        expectEqual(32'(active), 32'd1, "active during request");
        expectEqual(32'(memReq.size), cfg.wordSize ? 32'd2 : 32'd1, "memReq.size");
        if (!memReq.write) begin
          if (!trigSeen) begin
            errors++;
            $display("ERR %0t: read at %h issued before its start condition", $time,
                     memReq.addr);
          end
          expectEqual(memReq.addr, expSrc, "read address");
          expData = expSrc ^ DATA_PATTERN;
          expSrc = nextAddr(expSrc, cfg.srcCtl, cfg.wordSize);
        end else begin
          expectEqual(memReq.addr, expDst, "write address");
          expectEqual(memReq.wdata, expData, "write data");
          expDst = nextAddr(expDst, cfg.dstCtl, cfg.wordSize);
          unitsDone++;
          lastWrite = (unitsDone == int'(cfg.unitCount));
        end
      end
      if (endDue) begin
        unitsDone = 0;
        if (!cfg.repeatEn)
          chanOff = 1'b1;
        else if (cfg.dstCtl == addrIncReload)
          expDst = cfg.dstAddr; // dst restarts on every repeat
        if (cfg.repeatEn && cfg.startMode != startNow)
          trigSeen = 1'b0;
      end
      endDue = lastWrite;
      irqCount += int'(irq);
      disCount += int'(disableDma);
      if (rowDone) begin
        expectEqual(32'(irqCount), 32'(rowExpIrq), "irq pulses in row");
        expectEqual(32'(disCount), 32'(rowExpDis), "disableDma pulses in row");
        irqCount = 0;
        disCount = 0;
      end
      if (cfg != cfgSeen && cfg.enable) begin
        expSrc = cfg.srcAddr;
        expDst = cfg.dstAddr;
        unitsDone = 0;
        trigSeen = 1'b0;
        chanOff = 1'b0;
      end
      if (!cfg.enable && !active)
        chanOff = 1'b1;
      case (cfg.startMode)
        startHblank: trigSeen = trigSeen | (hcount[7:0] == HBLANK_LINE_END);
        startVblank: trigSeen = trigSeen | (vcount[7:0] == VBLANK_LINE);
        default: trigSeen = 1'b1;
      endcase
      cfgSeen = cfg;
    end
  end

endmodule : dmaChecker

`default_nettype wire

//--- testbench/dmaTb.sv
`timescale 1ns/10ps
`default_nettype none

module dmaTb;
  import dmaPkg::*;

  localparam int MEM_CREDITS = 2;
  localparam logic [31:0] DATA_PATTERN = 32'h5a3c96e1; // read data is address xor this
  localparam int NUM_ROWS = 6;

  typedef struct packed {
    dmaConfig_t cfg;
    logic [3:0] sweeps; // counter sweeps of 0..255 (none for startNow)
    logic [3:0] expIrq;
  } tbRow_t;

  logic clk = 1'b0;
  logic rst_b = 1'b1;
  dmaConfig_t cfg;
  logic [15:0] hcount;
  logic [15:0] vcount;
  memRsp_t memRsp = '0;
  logic creditReturn = 1'b0;
  memReq_t memReq;
  logic active;
  logic irq;
  logic disableDma;
  logic rowDone;
  logic [3:0] rowExpIrq;
  logic rowExpDis;
  int errCount;
  int checkCount;

  tbRow_t rows [NUM_ROWS];
  int cycleLimit;
  int cycleCount = 0;
  int lastCreditDue = 0;
  int irqTotal = 0;
  int disTotal = 0;
  logic [31:0] lcgState = 32'hf54132c3;
  int rspDue [$];
  logic [31:0] rspData [$];
  int creditDue [$];

  dmaChannel #(
    .MEM_CREDITS(MEM_CREDITS)
  ) i_dut (
    .clk, .rst_b, .cfg, .hcount, .vcount, .memRsp, .creditReturn, .memReq, .active,
    .irq, .disableDma
  );

  dmaChecker #(
    .MEM_CREDITS(MEM_CREDITS),
    .DATA_PATTERN(DATA_PATTERN)
  ) i_checker (
    .clk, .rst_b, .cfg, .hcount, .vcount, .memReq, .creditReturn, .active, .irq,
    .disableDma, .rowDone, .rowExpIrq, .rowExpDis, .errCount, .checkCount
  );

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic dmaConfig_t makeCfg(input logic [31:0] src, input logic [31:0] dst,
                                         input logic [13:0] units, input addrCtl_e srcCtl,
                                         input addrCtl_e dstCtl, input logic word,
                                         input logic rep, input startMode_e mode,
                                         input logic irqOn);
    dmaConfig_t c;
    c.srcAddr = src;
    c.dstAddr = dst;
    c.unitCount = units;
    c.srcCtl = srcCtl;
    c.dstCtl = dstCtl;
    c.wordSize = word;
    c.repeatEn = rep;
    c.startMode = mode;
    c.irqEn = irqOn;
    c.enable = 1'b1;
    return c;
  endfunction

  task automatic sweepCounters();
    for (int v = 0; v < 256; v++) begin
      @(negedge clk);
      hcount = 16'(v);
      vcount = 16'(v);
    end
    @(negedge clk);
    hcount = '0;
    vcount = '0;
  endtask

  task automatic waitForEnd(input int phase, input logic rep, input int irqBase,
                            input int disBase);
    do begin
      @(negedge clk);
    end while (!((disTotal != disBase) || (rep && (irqTotal - irqBase >= phase))));
  endtask

  initial begin
    forever #2 clk = ~clk;
  end

  // memory model that takes requests at the rising edge
  always @(posedge clk) begin : memCapture
    int due;
    if (rst_b) begin
      cycleCount = cycleCount + 1;
      irqTotal = irqTotal + int'(irq);
      disTotal = disTotal + int'(disableDma);
      if (memReq.valid) begin
        lcgState = lcgNext(lcgState);
        if (!memReq.write) begin
          rspDue.push_back(cycleCount + int'(lcgState[17:16])); // 0 to 3 cycles late
          rspData.push_back(memReq.addr ^ DATA_PATTERN);
        end
        lcgState = lcgNext(lcgState);
        due = cycleCount + int'(lcgState[17:16]);
        if (due <= lastCreditDue)
          due = lastCreditDue + 1; // one credit per cycle at most
        lastCreditDue = due;
        creditDue.push_back(due);
      end
    end
  end

  always @(negedge clk) begin : memRespond
    memRsp.valid = 1'b0;
    creditReturn = 1'b0;
    if (rspDue.size() != 0 && rspDue[0] <= cycleCount) begin
      memRsp.valid = 1'b1;
      memRsp.rdata = rspData.pop_front();
      void'(rspDue.pop_front());
    end
    if (creditDue.size() != 0 && creditDue[0] <= cycleCount) begin
      creditReturn = 1'b1;
      void'(creditDue.pop_front());
    end
  end

  initial begin : stimulus
    int irqBase;
    int disBase;
    int phases;
    cfg = '0;
    hcount = '0;
    vcount = '0;
    rowDone = 1'b0;
    rowExpIrq = '0;
    rowExpDis = 1'b0;
    rows[0] = '{makeCfg(32'h0200_0000, 32'h0300_0100, 14'd6, addrInc, addrInc, 1'b1, 1'b0,
                        startNow, 1'b1), 4'd0, 4'd1};
    rows[1] = '{makeCfg(32'h0800_0040, 32'h0400_00a0, 14'd5, addrDec, addrFixed, 1'b0, 1'b0,
                        startNow, 1'b1), 4'd0, 4'd1};
    rows[2] = '{makeCfg(32'h0300_0000, 32'h0600_0000, 14'd4, addrInc, addrInc, 1'b1, 1'b0,
                        startHblank, 1'b0), 4'd1, 4'd0};
    rows[3] = '{makeCfg(32'h0200_1000, 32'h0600_0200, 14'd3, addrInc, addrDec, 1'b0, 1'b0,
                        startVblank, 1'b1), 4'd1, 4'd1};
    rows[4] = '{makeCfg(32'h0800_2000, 32'h0400_00c0, 14'd3, addrInc, addrIncReload, 1'b1,
                        1'b1, startHblank, 1'b1), 4'd3, 4'd3};
    rows[5] = '{makeCfg(32'h0300_7ffc, 32'h0200_4000, 14'd8, addrFixed, addrDec, 1'b1, 1'b0,
                        startNow, 1'b1), 4'd0, 4'd1};
    cycleLimit = 2000;
    foreach (rows[i]) begin
      phases = (rows[i].sweeps == 0) ? 1 : int'(rows[i].sweeps);
      cycleLimit += int'(rows[i].cfg.unitCount) * phases * 20 + int'(rows[i].sweeps) * 256;
    end
    #1 rst_b = 1'b0; // ahead of the first rising edge
    repeat (3) @(negedge clk);
    rst_b = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      @(negedge clk);
      irqBase = irqTotal;
      disBase = disTotal;
      cfg = rows[r].cfg;
      phases = (rows[r].sweeps == 0) ? 1 : int'(rows[r].sweeps);
      for (int p = 1; p <= phases; p++) begin
        if (rows[r].sweeps != 0)
          sweepCounters();
        waitForEnd(p, rows[r].cfg.repeatEn, irqBase, disBase);
      end
      cfg.enable = 1'b0;
      rowDone = 1'b1;
      rowExpIrq = rows[r].expIrq;
      rowExpDis = !rows[r].cfg.repeatEn;
      @(negedge clk);
      rowDone = 1'b0;
      repeat (6) @(negedge clk); // let credits drain and the channel settle in stOff
    end
    repeat (10) @(negedge clk);
    $display("dma checks run %0d, errors %0d", checkCount, errCount);
    if (errCount == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial begin : watchdog
    @(posedge rst_b);
    repeat (cycleLimit) @(posedge clk);
    $display("watchdog expired after %0d cycles, transfers never completed", cycleLimit);
    $display("TEST FAILED");
    $finish;
  end

endmodule : dmaTb

`default_nettype wire
